// ==== common/gfx_pkg.sv ====
package gfx_pkg;

    // host bus address width, frame buffer plus the offset register
    localparam int ADDR_W = 16;

    // four pixels per word, pixel 0 in the low byte
    typedef logic [31:0] word_t;

    // one enable per byte lane
    typedef logic [3:0] byte_mask_t;

    // 3-3-2 pixel, red in the top bits
    typedef logic [7:0] color_t;

    localparam byte_mask_t mask_none = 4'b0000;
    localparam byte_mask_t mask_full = 4'b1111;

    // the half masks never reach the RAM
    // they select fill mode, one data bit per byte
    localparam byte_mask_t mask_half_lo = 4'b0011;
    localparam byte_mask_t mask_half_hi = 4'b1100;

endpackage

// ==== frame_buffer/frame_buffer_ram.sv ====
`timescale 1ns/1ps

module frame_buffer_ram #(
    parameter int FB_WORDS = 8,
    localparam int AW = (FB_WORDS > 1) ? $clog2(FB_WORDS) : 1
) (
    input  logic                vga_clk,
    input  logic [AW-1:0]       a_addr_i,
    input  gfx_pkg::byte_mask_t a_we_i,
    input  gfx_pkg::word_t      a_wdata_i,
    output gfx_pkg::word_t      a_rdata_o,
    input  logic [AW-1:0]       b_addr_i,
    output gfx_pkg::word_t      b_rdata_o
);

    // one memory per byte lane so each lane has its own write enable
    for (genvar i = 0; i < 4; i++) begin : g_lane
        logic [7:0] lane_mem [FB_WORDS];
        logic [7:0] a_q;
        logic [7:0] b_q;

        // port A, read-first on a write to the same word
        always_ff @(posedge vga_clk) begin
            if (a_we_i[i]) begin
                lane_mem[a_addr_i] <= a_wdata_i[8*i +: 8];
            end
            a_q <= lane_mem[a_addr_i];
        end

        // port B, video side
        always_ff @(posedge vga_clk) begin
            b_q <= lane_mem[b_addr_i];
        end

        assign a_rdata_o[8*i +: 8] = a_q;
        assign b_rdata_o[8*i +: 8] = b_q;
    end

    a_addr_range: assert property (@(posedge vga_clk) a_addr_i < FB_WORDS);
    b_addr_range: assert property (@(posedge vga_clk) b_addr_i < FB_WORDS);

endmodule

// ==== frame_buffer/bus_port.sv ====
`timescale 1ns/1ps

module bus_port #(
    parameter int FB_WORDS = 8,
    localparam int AW = (FB_WORDS > 1) ? $clog2(FB_WORDS) : 1
) (
    input  logic                       vga_clk,
    input  logic                       rst,
    input  logic                       req_valid_i,
    input  logic                       req_write_i,
    input  logic [gfx_pkg::ADDR_W-1:0] req_addr_i,
    input  gfx_pkg::word_t             req_wdata_i,
    input  gfx_pkg::byte_mask_t        req_mask_i,
    output logic                       req_ready_o,
    output logic                       rsp_valid_o,
    output gfx_pkg::word_t             rsp_rdata_o,
    input  logic                       rsp_ready_i,
    output logic [AW-1:0]              ram_addr_o,
    output gfx_pkg::byte_mask_t        ram_we_o,
    output gfx_pkg::word_t             ram_wdata_o,
    input  gfx_pkg::word_t             ram_rdata_i,
    input  logic                       frame_end_i,
    output logic [AW-1:0]              scroll_offset_o
);
    import gfx_pkg::*;

    // offset register sits right after the frame buffer
    localparam logic [ADDR_W-1:0] CFG_ADDR = ADDR_W'(FB_WORDS);

    typedef enum logic [1:0] {
        st_idle,
        st_rd_wait,
        st_rsp
    } state_t;

    state_t        state;
    logic          rsp_from_ram;
    logic [AW-1:0] pending_offset;
    logic          accept;
    logic          is_cfg;
    logic          fill_mode;

    function automatic word_t bit_expand(input logic [3:0] bits);
        word_t w;
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = {8{bits[i]}};
        end
        return w;
    endfunction

    assign req_ready_o = (state == st_idle);
    assign rsp_valid_o = (state == st_rsp);
    assign accept = req_valid_i && req_ready_o;
    assign is_cfg = (req_addr_i == CFG_ADDR);
    assign fill_mode = (req_mask_i == mask_half_lo) || (req_mask_i == mask_half_hi);

    // port A stays on the read address until the response is taken,
    // so the RAM output holds still under back-pressure
    assign rsp_rdata_o = rsp_from_ram ? ram_rdata_i : word_t'(pending_offset);

    always_ff @(posedge vga_clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
            rsp_from_ram <= 1'b0;
            ram_addr_o <= '0;
            ram_we_o <= mask_none;
        end else begin
            ram_we_o <= mask_none;
            case (state)
                st_idle: begin
                    if (accept && req_write_i && !is_cfg) begin
                        ram_addr_o <= req_addr_i[AW-1:0];
                        ram_we_o <= fill_mode ? mask_full : req_mask_i;
                    end else if (accept && !req_write_i) begin
                        if (is_cfg) begin
                            rsp_from_ram <= 1'b0;
                            state <= st_rsp;
                        end else begin
                            ram_addr_o <= req_addr_i[AW-1:0];
                            rsp_from_ram <= 1'b1;
                            state <= st_rd_wait;
                        end
                    end
                end
                // RAM latches the address this cycle
                st_rd_wait: begin
                    state <= st_rsp;
                end
                st_rsp: begin
                    if (rsp_ready_i) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge vga_clk) begin
        if (accept && req_write_i) begin
            ram_wdata_o <= fill_mode ? bit_expand(req_wdata_i[3:0]) : req_wdata_i;
        end
    end

    // new offset is shown from the next frame on
    always_ff @(posedge vga_clk or posedge rst) begin
        if (rst) begin
            pending_offset <= '0;
            scroll_offset_o <= '0;
        end else begin
            if (accept && req_write_i && is_cfg) begin
                pending_offset <= AW'(req_wdata_i % FB_WORDS);
            end
            if (frame_end_i) begin
                scroll_offset_o <= pending_offset;
            end
        end
    end

    rsp_blocks_req: assert property (
        @(posedge vga_clk) disable iff (rst)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && !req_ready_o
    );

    rsp_data_stable: assert property (
        @(posedge vga_clk) disable iff (rst)
        rsp_valid_o && !rsp_ready_i |=> $stable(rsp_rdata_o)
    );

    wr_addr_range: assert property (
        @(posedge vga_clk) disable iff (rst)
        accept && req_write_i |-> req_addr_i <= CFG_ADDR
    );

endmodule

// ==== logic/vga_timing.sv ====
`timescale 1ns/1ps

module vga_timing #(
    parameter int H_VISIBLE = 320,
    parameter int H_FRONT   = 8,
    parameter int H_SYNC    = 32,
    parameter int H_BACK    = 40,
    parameter int V_VISIBLE = 240,
    parameter int V_FRONT   = 3,
    parameter int V_SYNC    = 4,
    parameter int V_BACK    = 6,
    parameter bit HSYNC_POL = 1'b0,
    parameter bit VSYNC_POL = 1'b0
) (
    input  logic vga_clk,
    input  logic rst,
    output logic hsync_o,
    output logic vsync_o,
    output logic de_o,
    output logic frame_end_o
);

    // line and frame order: sync, back porch, visible, front porch
    localparam int H_TOTAL = H_SYNC + H_BACK + H_VISIBLE + H_FRONT;
    localparam int V_TOTAL = V_SYNC + V_BACK + V_VISIBLE + V_FRONT;
    localparam int H_START = H_SYNC + H_BACK;
    localparam int V_START = V_SYNC + V_BACK;
    localparam int HW = $clog2(H_TOTAL);
    localparam int VW = $clog2(V_TOTAL);

    logic [HW-1:0] h_cnt;
    logic [VW-1:0] v_cnt;
    logic          h_last;
    logic          v_last;
    logic          h_vis;
    logic          v_vis;

    assign h_last = (h_cnt == HW'(H_TOTAL - 1));
    assign v_last = (v_cnt == VW'(V_TOTAL - 1));
    assign h_vis = (h_cnt >= HW'(H_START)) &&
                   ({1'b0, h_cnt} < (HW + 1)'(H_START + H_VISIBLE));
    assign v_vis = (v_cnt >= VW'(V_START)) &&
                   ({1'b0, v_cnt} < (VW + 1)'(V_START + V_VISIBLE));

    always_ff @(posedge vga_clk or posedge rst) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
            v_cnt <= v_last ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // one register stage between the counters and the outputs
    always_ff @(posedge vga_clk or posedge rst) begin
        if (rst) begin
            hsync_o <= ~HSYNC_POL;
            vsync_o <= ~VSYNC_POL;
            de_o <= 1'b0;
            frame_end_o <= 1'b0;
        end else begin
            hsync_o <= (h_cnt < HW'(H_SYNC)) ? HSYNC_POL : ~HSYNC_POL;
            vsync_o <= (v_cnt < VW'(V_SYNC)) ? VSYNC_POL : ~VSYNC_POL;
            de_o <= h_vis && v_vis;
            frame_end_o <= h_last && v_last;
        end
    end

endmodule

// ==== logic/pixel_fetch.sv ====
`timescale 1ns/1ps

module pixel_fetch #(
    parameter int FB_WORDS = 8,
    localparam int AW = (FB_WORDS > 1) ? $clog2(FB_WORDS) : 1
) (
    input  logic             vga_clk,
    input  logic             rst,
    input  logic             hsync_i,
    input  logic             vsync_i,
    input  logic             de_i,
    input  logic             frame_end_i,
    input  logic [AW-1:0]    scroll_offset_i,
    output logic [AW-1:0]    ram_addr_o,
    input  gfx_pkg::word_t   ram_rdata_i,
    output logic             hsync_o,
    output logic             vsync_o,
    output logic             de_o,
    output gfx_pkg::color_t  rgb_o
);
    import gfx_pkg::*;

    localparam int PIX_TOTAL = FB_WORDS * 4;
    localparam int PW = $clog2(PIX_TOTAL + 1);
    localparam int SW = AW + 1;

    logic [PW-1:0] pix_cnt;
    logic [SW-1:0] word_base;
    logic [SW-1:0] word_sum;
    logic [1:0]    byte_sel;
    word_t         word_q;
    word_t         cur_word;

    // counts de cycles from the start of the frame
    always_ff @(posedge vga_clk or posedge rst) begin
        if (rst) begin
            pix_cnt <= '0;
        end else if (frame_end_i) begin
            pix_cnt <= '0;
        end else if (de_i) begin
            pix_cnt <= pix_cnt + 1'b1;
        end
    end

    assign word_base = SW'(pix_cnt >> 2);
    assign word_sum = word_base + SW'(scroll_offset_i);

    // both terms are below FB_WORDS so one subtraction wraps
    assign ram_addr_o = (word_sum >= SW'(FB_WORDS)) ? AW'(word_sum - SW'(FB_WORDS))
                                                  : AW'(word_sum);

    always_ff @(posedge vga_clk or posedge rst) begin
        if (rst) begin
            de_o <= 1'b0;
            byte_sel <= '0;
        end else begin
            de_o <= de_i;
            byte_sel <= pix_cnt[1:0];
        end
    end

    // syncs delayed to line up with rgb
    always_ff @(posedge vga_clk) begin
        hsync_o <= hsync_i;
        vsync_o <= vsync_i;
    end

    // word arrives with byte 0 and later bytes come from the latch
    always_ff @(posedge vga_clk) begin
        if (de_o && byte_sel == 2'd0) begin
            word_q <= ram_rdata_i;
        end
    end

    assign cur_word = (byte_sel == 2'd0) ? ram_rdata_i : word_q;
    assign rgb_o = de_o ? color_t'(cur_word[8*byte_sel +: 8]) : '0;

    pix_cnt_range: assert property (
        @(posedge vga_clk) disable iff (rst)
        de_i |-> pix_cnt < PW'(PIX_TOTAL)
    );

endmodule

// ==== logic/graphics_controller.sv ====
`timescale 1ns/1ps

module graphics_controller #(
    parameter int H_VISIBLE = 320,
    parameter int H_FRONT   = 8,
    parameter int H_SYNC    = 32,
    parameter int H_BACK    = 40,
    parameter int V_VISIBLE = 240,
    parameter int V_FRONT   = 3,
    parameter int V_SYNC    = 4,
    parameter int V_BACK    = 6,
    parameter bit HSYNC_POL = 1'b0,
    parameter bit VSYNC_POL = 1'b0
) (
    input  logic                       vga_clk,
    input  logic                       rst,
    input  logic                       req_valid_i,
    input  logic                       req_write_i,
    input  logic [gfx_pkg::ADDR_W-1:0] req_addr_i,
    input  gfx_pkg::word_t             req_wdata_i,
    input  gfx_pkg::byte_mask_t        req_mask_i,
    output logic                       req_ready_o,
    output logic                       rsp_valid_o,
    output gfx_pkg::word_t             rsp_rdata_o,
    input  logic                       rsp_ready_i,
    output logic                       hsync_o,
    output logic                       vsync_o,
    output logic                       de_o,
    output gfx_pkg::color_t            rgb_o
);
    import gfx_pkg::*;

    // one byte per visible pixel, four per word
    localparam int FB_WORDS = H_VISIBLE * V_VISIBLE / 4;
    localparam int AW = (FB_WORDS > 1) ? $clog2(FB_WORDS) : 1;

    logic [AW-1:0] ram_a_addr;
    byte_mask_t    ram_a_we;
    word_t         ram_a_wdata;
    word_t         ram_a_rdata;
    logic [AW-1:0] ram_b_addr;
    word_t         ram_b_rdata;
    logic [AW-1:0] scroll_offset;
    logic          tim_hsync;
    logic          tim_vsync;
    logic          tim_de;
    logic          frame_end;

    bus_port #(
        .FB_WORDS(FB_WORDS)
    ) u_bus_port (
        .vga_clk        (vga_clk),
        .rst            (rst),
        .req_valid_i    (req_valid_i),
        .req_write_i    (req_write_i),
        .req_addr_i     (req_addr_i),
        .req_wdata_i    (req_wdata_i),
        .req_mask_i     (req_mask_i),
        .req_ready_o    (req_ready_o),
        .rsp_valid_o    (rsp_valid_o),
        .rsp_rdata_o    (rsp_rdata_o),
        .rsp_ready_i    (rsp_ready_i),
        .ram_addr_o     (ram_a_addr),
        .ram_we_o       (ram_a_we),
        .ram_wdata_o    (ram_a_wdata),
        .ram_rdata_i    (ram_a_rdata),
        .frame_end_i    (frame_end),
        .scroll_offset_o(scroll_offset)
    );

    frame_buffer_ram #(
        .FB_WORDS(FB_WORDS)
    ) u_frame_buffer_ram (
        .vga_clk  (vga_clk),
        .a_addr_i (ram_a_addr),
        .a_we_i   (ram_a_we),
        .a_wdata_i(ram_a_wdata),
        .a_rdata_o(ram_a_rdata),
        .b_addr_i (ram_b_addr),
        .b_rdata_o(ram_b_rdata)
    );

    vga_timing #(
        .H_VISIBLE(H_VISIBLE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_VISIBLE(V_VISIBLE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK),
        .HSYNC_POL(HSYNC_POL),
        .VSYNC_POL(VSYNC_POL)
    ) u_vga_timing (
        .vga_clk    (vga_clk),
        .rst        (rst),
        .hsync_o    (tim_hsync),
        .vsync_o    (tim_vsync),
        .de_o       (tim_de),
        .frame_end_o(frame_end)
    );

    pixel_fetch #(
        .FB_WORDS(FB_WORDS)
    ) u_pixel_fetch (
        .vga_clk        (vga_clk),
        .rst            (rst),
        .hsync_i        (tim_hsync),
        .vsync_i        (tim_vsync),
        .de_i           (tim_de),
        .frame_end_i    (frame_end),
        .scroll_offset_i(scroll_offset),
        .ram_addr_o     (ram_b_addr),
        .ram_rdata_i    (ram_b_rdata),
        .hsync_o        (hsync_o),
        .vsync_o        (vsync_o),
        .de_o           (de_o),
        .rgb_o          (rgb_o)
    );

endmodule

// ==== testbench/graphics_controller_tb.sv ====
`timescale 1ns/1ps

module graphics_controller_tb;
    import gfx_pkg::*;

    // tiny screen of 8 by 4 visible pixels
    localparam int H_VISIBLE = 8;
    localparam int H_FRONT = 2;
    localparam int H_SYNC = 2;
    localparam int H_BACK = 2;
    localparam int V_VISIBLE = 4;
    localparam int V_FRONT = 2;
    localparam int V_SYNC = 1;
    localparam int V_BACK = 2;

    localparam int FB_WORDS = H_VISIBLE * V_VISIBLE / 4;
    localparam int CFG_ADDR = FB_WORDS;
    localparam int LINE_CYCLES = H_SYNC + H_BACK + H_VISIBLE + H_FRONT;
    localparam int FRAME_CYCLES = LINE_CYCLES * (V_SYNC + V_BACK + V_VISIBLE + V_FRONT);
    localparam int SCROLL = 3;
    localparam int HOLD_CYCLES = 5;

    localparam int OP_WRITE = 0;
    localparam int OP_READ = 1;
    localparam int OP_READ_HELD = 2;

    logic              vga_clk = 1'b0;
    logic              rst;
    logic              req_valid;
    logic              req_write;
    logic [ADDR_W-1:0] req_addr;
    word_t             req_wdata;
    byte_mask_t        req_mask;
    logic              req_ready;
    logic              rsp_valid;
    word_t             rsp_rdata;
    logic              rsp_ready;
    logic              hsync;
    logic              vsync;
    logic              de;
    color_t            rgb;

    // operation table with expected values from the shadow model
    int         op_kind[$];
    int         op_addr[$];
    word_t      op_data[$];
    byte_mask_t op_mask[$];
    word_t      op_expect[$];

    word_t shadow_mem [FB_WORDS];
    int    model_offset;
    int    error_count = 0;
    int    test_count = 0;
    int    good_count = 0;
    int    cycle_count = 0;
    int    cycle_limit = 0;

    graphics_controller #(
        .H_VISIBLE(H_VISIBLE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_VISIBLE(V_VISIBLE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK),
        .HSYNC_POL(1'b1),
        .VSYNC_POL(1'b1)
    ) uut (
        .vga_clk    (vga_clk),
        .rst        (rst),
        .req_valid_i(req_valid),
        .req_write_i(req_write),
        .req_addr_i (req_addr),
        .req_wdata_i(req_wdata),
        .req_mask_i (req_mask),
        .req_ready_o(req_ready),
        .rsp_valid_o(rsp_valid),
        .rsp_rdata_o(rsp_rdata),
        .rsp_ready_i(rsp_ready),
        .hsync_o    (hsync),
        .vsync_o    (vsync),
        .de_o       (de),
        .rgb_o      (rgb)
    );

    always #4 vga_clk = ~vga_clk;

    always @(posedge vga_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("run did not finish within %0d cycles", cycle_limit);
            $display("test failed");
            $finish;
        end
    end

    function automatic word_t merge_bytes(word_t old_word, word_t data, byte_mask_t mask);
        word_t w;
        w = old_word;
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) begin
                w[8*i +: 8] = data[8*i +: 8];
            end
        end
        return w;
    endfunction

    // byte i is all ones or all zeros after data bit i
    function automatic word_t fill_word(word_t data);
        word_t w;
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = data[i] ? 8'hff : 8'h00;
        end
        return w;
    endfunction

    // random mask that stays out of fill mode
    function automatic byte_mask_t plain_mask();
        byte_mask_t m;
        m = byte_mask_t'($urandom_range(15, 0));
        if (m == mask_half_lo || m == mask_half_hi) begin
            m = m ^ 4'b0001;
        end
        return m;
    endfunction

    function automatic void add_write(int addr, word_t data, byte_mask_t mask);
        if (addr == CFG_ADDR) begin
            model_offset = int'(data % FB_WORDS);
        end else if (mask == mask_half_lo || mask == mask_half_hi) begin
            shadow_mem[addr] = fill_word(data);
        end else begin
            shadow_mem[addr] = merge_bytes(shadow_mem[addr], data, mask);
        end
        op_kind.push_back(OP_WRITE);
        op_addr.push_back(addr);
        op_data.push_back(data);
        op_mask.push_back(mask);
        op_expect.push_back('0);
    endfunction

    function automatic void add_read(int addr, bit held);
        op_kind.push_back(held ? OP_READ_HELD : OP_READ);
        op_addr.push_back(addr);
        op_data.push_back('0);
        op_mask.push_back(mask_none);
        op_expect.push_back((addr == CFG_ADDR) ? word_t'(model_offset) : shadow_mem[addr]);
    endfunction

    function automatic void build_table();
        for (int a = 0; a < FB_WORDS; a++) begin
            add_write(a, $urandom(), mask_full);
        end
        for (int a = 0; a < FB_WORDS; a++) begin
            add_write(a, $urandom(), plain_mask());
            add_read(a, 1'b0);
        end
        add_write(2, $urandom(), mask_half_lo);
        add_read(2, 1'b0);
        // upper bits set on purpose since only bits 3..0 count
        add_write(5, 32'hffff_fff6, mask_half_hi);
        add_read(5, 1'b0);
        add_read(6, 1'b1);
        add_write(CFG_ADDR, SCROLL, mask_full);
        add_read(CFG_ADDR, 1'b0);
    endfunction

    function automatic string op_name(int idx);
        string kind;
        case (op_kind[idx])
            OP_WRITE: kind = "write";
            OP_READ: kind = "read";
            default: kind = "held read";
        endcase
        return $sformatf("op %0d %s addr %0d", idx, kind, op_addr[idx]);
    endfunction

    function automatic void report_test(string name, bit ok);
        test_count++;
        if (ok) begin
            good_count++;
            $display("%s: pass", name);
        end else begin
            $display("%s: FAIL", name);
        end
    endfunction

    // starts on a falling edge and returns on the one after acceptance
    task automatic issue_request(input int kind, input int addr, input word_t data,
                                 input byte_mask_t mask);
        req_valid = 1'b1;
        req_write = (kind == OP_WRITE);
        req_addr = ADDR_W'(addr);
        req_wdata = data;
        req_mask = mask;
        while (!req_ready) begin
            @(negedge vga_clk);
        end
        @(negedge vga_clk);
        req_valid = 1'b0;
    endtask

    task automatic run_op(input int idx);
        int    errors_before;
        int    latency;
        int    want_latency;
        word_t held;
        string name;
        errors_before = error_count;
        name = op_name(idx);
        if (op_kind[idx] == OP_READ_HELD) begin
            rsp_ready = 1'b0;
        end
        issue_request(op_kind[idx], op_addr[idx], op_data[idx], op_mask[idx]);
        if (op_kind[idx] == OP_WRITE) begin
            assert (!rsp_valid && req_ready) else begin
                $display("%s: write produced a response or blocked the bus", name);
                error_count++;
            end
        end else begin
            want_latency = (op_addr[idx] == CFG_ADDR) ? 1 : 2;
            latency = 1;
            while (!rsp_valid) begin
                @(negedge vga_clk);
                latency++;
            end
            assert (latency == want_latency) else begin
                $display("ERROR %s latency: expected %0d, actual %0d",
                         name, want_latency, latency);
                error_count++;
            end
            if (op_kind[idx] == OP_READ_HELD) begin
                held = rsp_rdata;
                repeat (HOLD_CYCLES) begin
                    @(negedge vga_clk);
                    assert (rsp_valid && !req_ready) else begin
                        $display("%s: response dropped or bus reopened while held", name);
                        error_count++;
                    end
                    assert (rsp_rdata === held) else begin
                        $display("ERROR %s held data: expected %h, actual %h",
                                 name, held, rsp_rdata);
                        error_count++;
                    end
                end
                rsp_ready = 1'b1;
            end
            assert (rsp_rdata === op_expect[idx]) else begin
                $display("ERROR %s: expected %h, actual %h", name, op_expect[idx], rsp_rdata);
                error_count++;
            end
            @(negedge vga_clk);
            assert (!rsp_valid && req_ready) else begin
                $display("%s: response still pending after the handshake", name);
                error_count++;
            end
        end
        report_test(name, error_count == errors_before);
    endtask

    task automatic wait_vsync_rise();
        logic prev;
        prev = vsync;
        @(negedge vga_clk);
        while (!(vsync && !prev)) begin
            prev = vsync;
            @(negedge vga_clk);
        end
    endtask

    task automatic check_video_frame();
        int     video_bad;
        int     sync_bad;
        int     cyc;
        int     de_count;
        int     v_high;
        int     h_run;
        int     last_h_rise;
        int     word_idx;
        logic   prev_h;
        logic   prev_v;
        color_t want;
        video_bad = 0;
        sync_bad = 0;
        cyc = 0;
        de_count = 0;
        v_high = 0;
        h_run = 0;
        last_h_rise = -1;
        prev_h = 1'b0;
        prev_v = 1'b0;
        // second frame start is sure to run with the new offset
        wait_vsync_rise();
        wait_vsync_rise();
        while (!(cyc > 0 && vsync && !prev_v)) begin
            if (de) begin
                word_idx = (de_count / 4 + model_offset) % FB_WORDS;
                want = shadow_mem[word_idx][8*(de_count % 4) +: 8];
                assert (rgb === want) else begin
                    $display("ERROR video scan pixel %0d: expected %h, actual %h",
                             de_count, want, rgb);
                    video_bad++;
                end
                assert (!hsync && !vsync) else begin
                    $display("data enable overlaps an active sync at cycle %0d", cyc);
                    sync_bad++;
                end
                de_count++;
            end else begin
                assert (rgb === 8'h00) else begin
                    $display("ERROR video scan blank cycle %0d: expected 00, actual %h",
                             cyc, rgb);
                    video_bad++;
                end
            end
            if (hsync) begin
                if (!prev_h) begin
                    if (last_h_rise >= 0) begin
                        assert (cyc - last_h_rise == LINE_CYCLES) else begin
                            $display("ERROR sync structure hsync period: %s %0d, actual %0d",
                                     "expected", LINE_CYCLES, cyc - last_h_rise);
                            sync_bad++;
                        end
                    end
                    last_h_rise = cyc;
                end
                h_run++;
            end else if (prev_h) begin
                assert (h_run == H_SYNC) else begin
                    $display("ERROR sync structure hsync width: expected %0d, actual %0d",
                             H_SYNC, h_run);
                    sync_bad++;
                end
                h_run = 0;
            end
            if (vsync) begin
                v_high++;
            end
            prev_h = hsync;
            prev_v = vsync;
            @(negedge vga_clk);
            cyc++;
        end
        assert (de_count == FB_WORDS * 4) else begin
            $display("ERROR video scan de cycles: expected %0d, actual %0d",
                     FB_WORDS * 4, de_count);
            video_bad++;
        end
        assert (cyc == FRAME_CYCLES) else begin
            $display("ERROR sync structure frame length: expected %0d, actual %0d",
                     FRAME_CYCLES, cyc);
            sync_bad++;
        end
        assert (v_high == LINE_CYCLES * V_SYNC) else begin
            $display("ERROR sync structure vsync width: expected %0d, actual %0d",
                     LINE_CYCLES * V_SYNC, v_high);
            sync_bad++;
        end
        error_count += video_bad + sync_bad;
        report_test("video scan", video_bad == 0);
        report_test("sync structure", sync_bad == 0);
    endtask

    initial begin
        void'($urandom(32'h97ef));
        rst = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr = '0;
        req_wdata = '0;
        req_mask = mask_none;
        rsp_ready = 1'b1;
        model_offset = 0;
        build_table();
        cycle_limit = op_kind.size() * 8 + 3 * FRAME_CYCLES + 200;
        repeat (3) @(negedge vga_clk);
        rst = 1'b0;
        @(negedge vga_clk);
        for (int i = 0; i < op_kind.size(); i++) begin
            run_op(i);
        end
        check_video_frame();
        $display("summary: %0d tests, %0d good, %0d bad, %0d check errors",
                 test_count, good_count, test_count - good_count, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== graphics_controller.f ====
common/gfx_pkg.sv
frame_buffer/frame_buffer_ram.sv
frame_buffer/bus_port.sv
logic/vga_timing.sv
logic/pixel_fetch.sv
logic/graphics_controller.sv
testbench/graphics_controller_tb.sv

// ==== Makefile ====
# Verilator simulation of the graphics controller

VERILATOR ?= verilator
TOP       ?= graphics_controller_tb
FILELIST  ?= graphics_controller.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= test passed

.PHONY: sim clean

# build, run, and fail unless the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | awk -v msg="$(PASS_MSG)" \
		'{ print } $$0 == msg { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)
